// File: hdl/pixel_fifo.sv
// Show-ahead pixel FIFO. The head entry is valid on fifo_pixel whenever fifo_valid is high.
// A push while full and a pop while empty are ignored.
module pixel_fifo import pixel_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               push,
	input  logic [PIXEL_W-1:0] push_pixel,
	output logic               full,
	input  logic               pop,
	output logic [PIXEL_W-1:0] fifo_pixel,
	output logic               fifo_valid
);

	logic [PIXEL_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
	assign fifo_valid = (count != '0);
	assign fifo_pixel = mem[rd_ptr];

	assign do_push = push && !full;
	assign do_pop = pop && fifo_valid;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_pixel;
		end
	end

	// Pointers wrap on their own since the depth is a power of two.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// File: hdl/pixel_pkg.sv
// Pixel width, FIFO sizing and the rule for splitting a pixel into two bytes.
// PIXEL_W - HIGH_LSB must equal BYTE_W, and FIFO_DEPTH must equal 2**FIFO_AW.
package pixel_pkg;

	// Pixel and byte widths.
	localparam int PIXEL_W = 12;
	localparam int BYTE_W = 8;

	// Lowest pixel bit carried in the high byte.
	// The low byte holds the bits below it, zero padded on top.
	localparam int HIGH_LSB = 4;

	// Input buffer size.
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW = 3;

endpackage

// File: hdl/pixel_uart_top.sv
// Pixel stream in, UART frames out. A pixel is accepted when pixel_valid and pixel_ready are high.
// The producer must hold its pixel while pixel_ready is low.
module pixel_uart_top import pixel_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [PIXEL_W-1:0] pixel,
	input  logic               pixel_valid,
	output logic               pixel_ready,
	output logic               uart_out,
	output logic               pixel_sent
);

	logic push;
	logic full;
	logic [PIXEL_W-1:0] fifo_pixel;
	logic fifo_valid;
	logic fifo_pop;
	logic [BYTE_W-1:0] data_tx;
	logic tx_start;
	logic tx_ready;
	logic tx_done;

	assign pixel_ready = !full;
	assign push = pixel_valid && pixel_ready;

	pixel_fifo pixel_fifo_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.push       (push),
		.push_pixel (pixel),
		.full       (full),
		.pop        (fifo_pop),
		.fifo_pixel (fifo_pixel),
		.fifo_valid (fifo_valid)
	);

	send_pixel send_pixel_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.fifo_pixel (fifo_pixel),
		.fifo_valid (fifo_valid),
		.fifo_pop   (fifo_pop),
		.data_tx    (data_tx),
		.tx_start   (tx_start),
		.tx_ready   (tx_ready),
		.tx_done    (tx_done),
		.pixel_sent (pixel_sent)
	);

	uart_tx uart_tx_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.data_tx  (data_tx),
		.tx_start (tx_start),
		.uart_out (uart_out),
		.tx_ready (tx_ready),
		.tx_done  (tx_done)
	);

endmodule

// File: hdl/send_pixel.sv
// Sends the FIFO head pixel as a high byte frame, then a low byte frame with four zero pad bits.
// A pixel is popped only when the transmitter is idle. pixel_sent marks the end of the low frame.
module send_pixel import pixel_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [PIXEL_W-1:0] fifo_pixel,
	input  logic               fifo_valid,
	output logic               fifo_pop,
	output logic [BYTE_W-1:0]  data_tx,
	output logic               tx_start,
	input  logic               tx_ready,
	input  logic               tx_done,
	output logic               pixel_sent
);

	typedef enum logic [1:0] {
		IDLE,
		SEND_HIGH_BYTE,
		SEND_LOW_BYTE
	} state_t;

	state_t state;
	state_t next_state;
	logic [HIGH_LSB-1:0] low_nibble_q;
	logic [1:0] done_cnt;
	logic [BYTE_W-1:0] high_byte;
	logic [BYTE_W-1:0] low_byte;

	// High byte goes out in the pop cycle, straight from the FIFO head.
	assign high_byte = fifo_pixel[PIXEL_W-1:HIGH_LSB];
	assign low_byte = {{(BYTE_W - HIGH_LSB){1'b0}}, low_nibble_q};

	// Only the low nibble is still needed once the pixel has been popped.
	always_ff @(posedge clk) begin
		if (fifo_pop) begin
			low_nibble_q <= fifo_pixel[HIGH_LSB-1:0];
		end
	end

	// Frames finished for the current pixel.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done_cnt <= '0;
		end else if (fifo_pop) begin
			done_cnt <= '0;
		end else if (tx_done) begin
			done_cnt <= done_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		fifo_pop = 1'b0;
		tx_start = 1'b0;
		pixel_sent = 1'b0;
		data_tx = low_byte;

		case (state)
			IDLE: begin
				data_tx = high_byte;
				if (fifo_valid && tx_ready) begin
					fifo_pop = 1'b1;
					tx_start = 1'b1;
					next_state = SEND_HIGH_BYTE;
				end
			end
			SEND_HIGH_BYTE: begin
				// tx_ready comes back with the high frame's tx_done.
				if (tx_ready) begin
					tx_start = 1'b1;
					next_state = SEND_LOW_BYTE;
				end
			end
			SEND_LOW_BYTE: begin
				if (tx_done && done_cnt == 2'd1) begin
					pixel_sent = 1'b1;
					next_state = IDLE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

// File: hdl/uart_pkg.sv
// Serial line format, fixed at build time with no runtime baud or parity selection.
// CLKS_PER_BIT is a short simulation value and must be at least 2.
package uart_pkg;

	// Clock cycles per serial bit.
	// A board with a 50 MHz clock at 9600 baud would use 50_000_000 / 9600.
	localparam int CLKS_PER_BIT = 8;

	// Data bits per frame, sent LSB first.
	localparam int DATA_BITS = 8;

	// Start, data, parity and stop bits.
	localparam int FRAME_BITS = 1 + DATA_BITS + 1 + 1;

	// Parity sense, 0 gives even parity.
	localparam bit PARITY_ODD = 1'b0;

	// Counter widths.
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int BIT_IDX_W = $clog2(DATA_BITS);

endpackage

// File: hdl/uart_tx.sv
// Sends one byte as start, data LSB first, parity and stop. tx_start is taken only in idle.
// uart_out is registered, so the start bit shows one edge after the strobe.
module uart_tx import uart_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic [DATA_BITS-1:0] data_tx,
	input  logic                 tx_start,
	output logic                 uart_out,
	output logic                 tx_ready,
	output logic                 tx_done
);

	typedef enum logic [2:0] {
		IDLE,
		START,
		DATA,
		PARITY,
		STOP
	} tx_state_t;

	tx_state_t state;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [BIT_IDX_W-1:0] bit_idx;
	logic [DATA_BITS-1:0] shift_q;
	logic parity_q;
	logic bit_end;
	logic last_data;
	logic load;

	assign bit_end = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));
	assign last_data = (bit_idx == BIT_IDX_W'(DATA_BITS - 1));
	assign load = (state == IDLE) && tx_start;
	assign tx_ready = (state == IDLE);

	// Data shifter. Bit 0 is always the next data bit to go out.
	always_ff @(posedge clk) begin
		if (load) begin
			shift_q <= data_tx;
		end else if (bit_end && (state == START || state == DATA)) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
			parity_q <= PARITY_ODD;
			uart_out <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;

			// Bit timer runs only while a frame is on the line.
			if (state == IDLE || bit_end) begin
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			case (state)
				IDLE: begin
					uart_out <= 1'b1;
					if (tx_start) begin
						state <= START;
						uart_out <= 1'b0;
						bit_idx <= '0;
						parity_q <= PARITY_ODD;
					end
				end
				START: begin
					if (bit_end) begin
						state <= DATA;
						uart_out <= shift_q[0];
						parity_q <= parity_q ^ shift_q[0];
					end
				end
				DATA: begin
					if (bit_end) begin
						if (last_data) begin
							// Parity already covers all data bits here.
							state <= PARITY;
							uart_out <= parity_q;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							uart_out <= shift_q[0];
							parity_q <= parity_q ^ shift_q[0];
						end
					end
				end
				PARITY: begin
					if (bit_end) begin
						state <= STOP;
						uart_out <= 1'b1;
					end
				end
				STOP: begin
					if (bit_end) begin
						state <= IDLE;
						tx_done <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
					uart_out <= 1'b1;
				end
			endcase
		end
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the pixel UART testbench with Verilator.
# A failing check ends the simulation through $fatal, which gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_pixel_uart -Mdir obj_dir -f vlog.f

./obj_dir/Vtb_pixel_uart

// File: tb/tb_pixel_uart.sv
// Streams one back to back burst of random pixels, longer than the FIFO, into the DUT.
// A line receiver model decodes the frames, which are compared with the pixels in order.
module tb_pixel_uart import uart_pkg::*, pixel_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam int NUM_PIXELS = 24;
	localparam int TIMEOUT_MARGIN = 1000;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + TIMEOUT_MARGIN
		+ NUM_PIXELS * 2 * FRAME_BITS * CLKS_PER_BIT;

	logic clk;
	logic arst_n;
	logic [PIXEL_W-1:0] pixel;
	logic pixel_valid;
	logic pixel_ready;
	logic uart_out;
	logic pixel_sent;

	integer seed;
	logic [PIXEL_W-1:0] exp_q[$];
	logic [BYTE_W:0] rx_q[$];
	int frames_rx = 0;
	int sent_count = 0;
	int checked = 0;
	bit saw_full = 1'b0;

	pixel_uart_top pixel_uart_top_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.pixel       (pixel),
		.pixel_valid (pixel_valid),
		.pixel_ready (pixel_ready),
		.uart_out    (uart_out),
		.pixel_sent  (pixel_sent)
	);

	task automatic stop_run();
		$display("Checks failed");
		$fatal(1, "Stopping at the first error.");
	endtask

	task automatic value_error(input string test, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		$display("[ERROR] %s: expected %0h, actual %0h", test, exp_val, act_val);
		stop_run();
	endtask

	task automatic plain_error(input string what);
		$display("Error: %s", what);
		stop_run();
	endtask

	// Expected frames of one pixel as {parity, data} pairs, high frame in the upper half.
	function automatic logic [2*BYTE_W+1:0] ref_frames(input logic [PIXEL_W-1:0] p);
		logic [7:0] hi;
		logic [7:0] lo;
		int ones_hi;
		int ones_lo;
		hi = p[11:4];
		lo = {4'h0, p[3:0]};
		ones_hi = 0;
		ones_lo = 0;
		for (int i = 0; i < 8; i++) begin
			ones_hi += int'(hi[i]);
			ones_lo += int'(lo[i]);
		end
		// Even parity makes data plus parity bit hold an even number of ones.
		return {ones_hi % 2 == 1, hi, ones_lo % 2 == 1, lo};
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("The run timed out after %0d clock cycles.", TIMEOUT_CYCLES);
		stop_run();
	end

	initial begin : stimulus
		int accepted;
		accepted = 0;
		seed = 32'haad0e59b;
		arst_n = 1'b0;
		pixel = '0;
		pixel_valid = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		assert (uart_out == 1'b1) else value_error("reset_uart_out", 32'd1, 32'(uart_out));
		assert (pixel_ready == 1'b1) else value_error("reset_ready", 32'd1, 32'(pixel_ready));

		pixel_valid <= 1'b1;
		pixel <= PIXEL_W'($random(seed));
		while (accepted < NUM_PIXELS) begin
			@(posedge clk);
			if (pixel_ready) begin
				exp_q.push_back(pixel);
				accepted++;
				if (accepted < NUM_PIXELS) begin
					pixel <= PIXEL_W'($random(seed));
				end else begin
					pixel_valid <= 1'b0;
				end
			end else begin
				saw_full = 1'b1;
			end
		end
		assert (saw_full) else value_error("back_pressure", 32'd1, 32'(saw_full));

		while (sent_count < NUM_PIXELS) @(posedge clk);
		// Idle for a full frame so a stray frame or pulse would show up.
		repeat (2 * FRAME_BITS * CLKS_PER_BIT) @(posedge clk);
		assert (sent_count == NUM_PIXELS)
			else value_error("pixel_sent_count", 32'(NUM_PIXELS), 32'(sent_count));
		assert (frames_rx == 2 * NUM_PIXELS)
			else value_error("frame_count", 32'(2 * NUM_PIXELS), 32'(frames_rx));
		assert (checked == NUM_PIXELS)
			else value_error("pixels_compared", 32'(NUM_PIXELS), 32'(checked));
		$display("All checks passed");
		$finish;
	end

	// Line receiver. Each bit window must be stable and is sampled at mid-bit.
	initial begin : line_receiver
		logic [FRAME_BITS-1:0] bits;
		logic first;
		@(posedge arst_n);
		forever begin
			@(negedge uart_out);
			for (int b = 0; b < FRAME_BITS; b++) begin
				for (int c = 1; c <= CLKS_PER_BIT; c++) begin
					@(posedge clk);
					if (c == 1) begin
						first = uart_out;
					end
					assert (uart_out == first)
						else plain_error("uart_out changed inside a bit time.");
					if (c == CLKS_PER_BIT / 2) begin
						bits[b] = uart_out;
					end
				end
			end
			assert (bits[0] == 1'b0) else value_error("start_bit", 32'd0, 32'(bits[0]));
			assert (bits[FRAME_BITS-1] == 1'b1)
				else value_error("stop_bit", 32'd1, 32'(bits[FRAME_BITS-1]));
			rx_q.push_back(bits[FRAME_BITS-2:1]);
			frames_rx++;
		end
	end

	// Pairs received frames with accepted pixels, oldest first.
	initial begin : compare_frames
		logic [2*BYTE_W+1:0] exp_frames;
		logic [BYTE_W:0] hi_frame;
		logic [BYTE_W:0] lo_frame;
		forever begin
			@(posedge clk);
			if (rx_q.size() >= 2) begin
				assert (exp_q.size() != 0)
					else plain_error("a frame pair arrived with no accepted pixel to match.");
				exp_frames = ref_frames(exp_q.pop_front());
				hi_frame = rx_q.pop_front();
				lo_frame = rx_q.pop_front();
				assert (hi_frame[BYTE_W-1:0] == exp_frames[2*BYTE_W:BYTE_W+1])
					else value_error("high_byte", 32'(exp_frames[2*BYTE_W:BYTE_W+1]),
						32'(hi_frame[BYTE_W-1:0]));
				assert (hi_frame[BYTE_W] == exp_frames[2*BYTE_W+1])
					else value_error("high_parity", 32'(exp_frames[2*BYTE_W+1]),
						32'(hi_frame[BYTE_W]));
				assert (lo_frame[BYTE_W-1:0] == exp_frames[BYTE_W-1:0])
					else value_error("low_byte", 32'(exp_frames[BYTE_W-1:0]),
						32'(lo_frame[BYTE_W-1:0]));
				assert (lo_frame[BYTE_W] == exp_frames[BYTE_W])
					else value_error("low_parity", 32'(exp_frames[BYTE_W]), 32'(lo_frame[BYTE_W]));
				checked++;
			end
		end
	end

	// Each pixel_sent pulse must come after the stop bit of its low frame.
	initial begin : count_pulses
		forever begin
			@(posedge clk);
			if (pixel_sent) begin
				sent_count++;
				assert (frames_rx == 2 * sent_count)
					else value_error("pixel_sent_after_low_frame", 32'(2 * sent_count),
						32'(frames_rx));
			end
		end
	end

endmodule

// File: tb/uart_tx_asserts.sv
// Framing checks on the UART transmitter, bound into every uart_tx instance.
// All checks are held off while arst_n is low.
module uart_tx_asserts (
	input logic clk,
	input logic arst_n,
	input logic tx_start,
	input logic uart_out,
	input logic tx_ready,
	input logic tx_done
);

	// An idle transmitter keeps the line high.
	idle_line_high: assert property (
		@(posedge clk) disable iff (!arst_n) tx_ready |-> uart_out
	) else $error("uart_out is low while the transmitter is idle");

	// The sender may only strobe an idle transmitter.
	start_only_when_ready: assert property (
		@(posedge clk) disable iff (!arst_n) tx_start |-> tx_ready
	) else $error("tx_start seen while tx_ready is low");

	// Start bit goes out at the edge after the strobe.
	start_bit_follows: assert property (
		@(posedge clk) disable iff (!arst_n) tx_start |=> (!uart_out && !tx_ready)
	) else $error("no start bit in the cycle after tx_start");

	done_single_cycle: assert property (
		@(posedge clk) disable iff (!arst_n) tx_done |=> !tx_done
	) else $error("tx_done held high for more than one cycle");

endmodule

bind uart_tx uart_tx_asserts uart_tx_asserts_i (
	.clk      (clk),
	.arst_n   (arst_n),
	.tx_start (tx_start),
	.uart_out (uart_out),
	.tx_ready (tx_ready),
	.tx_done  (tx_done)
);

// File: vlog.f
hdl/uart_pkg.sv
hdl/pixel_pkg.sv
hdl/uart_tx.sv
hdl/send_pixel.sv
hdl/pixel_fifo.sv
hdl/pixel_uart_top.sv
tb/uart_tx_asserts.sv
tb/tb_pixel_uart.sv
